/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = spi_cmd_tb
FILELIST  = sources.f
SIM_ARGS  = +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

/* sources.f */
src/spi_cmd_pkg.sv
src/cmd_fifo.sv
src/spi_master.sv
src/spi_cmd_top.sv
test/spi_slave_model.sv
test/spi_master_assertions.sv
test/spi_cmd_tb.sv

/* src/cmd_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  spi_cmd_pkg::spi_cmd_t in_cmd,
  input  logic                  in_valid,
  output logic                  in_ready,
  output spi_cmd_pkg::spi_cmd_t out_cmd,
  output logic                  out_valid,
  input  logic                  out_ready
);

  localparam int IDX_W = $clog2(FIFO_DEPTH);

  // One extra bit on each pointer separates full from empty.
  typedef logic [IDX_W:0] fifo_ptr_t;

  spi_cmd_pkg::spi_cmd_t mem [FIFO_DEPTH];

  fifo_ptr_t wr_ptr;
  fifo_ptr_t rd_ptr;
  logic      full;
  logic      empty;
  logic      push;
  logic      pop;

  // ~~~~~~~~~~~~~~~~~~~~
  // Status

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[IDX_W] != rd_ptr[IDX_W]) &&
                 (wr_ptr[IDX_W-1:0] == rd_ptr[IDX_W-1:0]);

  assign in_ready  = !full;
  assign out_valid = !empty;

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // ~~~~~~~~~~~~~~~~~~~~
  // Pointers and storage

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wr_ptr[IDX_W-1:0]] <= in_cmd;
    end
  end

  assign out_cmd = mem[rd_ptr[IDX_W-1:0]]; // Head word, visible the cycle after its push.

endmodule

`default_nettype wire

/* src/spi_cmd_pkg.sv */
`default_nettype none

package spi_cmd_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Field widths

  localparam int ADDR_BITS = 3;
  localparam int DATA_BITS = 8;

  localparam int CMD_BITS  = 1 + ADDR_BITS + DATA_BITS; // Length of the command phase.
  localparam int READ_BITS = DATA_BITS;                 // Length of the read phase.

  typedef logic [ADDR_BITS-1:0] spi_addr_t;
  typedef logic [DATA_BITS-1:0] spi_data_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // Command word

  typedef struct packed {
    logic      write; // Set for a write, clear for a read.
    spi_addr_t addr;
    spi_data_t data;
  } spi_cmd_t;

endpackage

`default_nettype wire

/* src/spi_cmd_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_top #(
  parameter int FIFO_DEPTH = 4,
  parameter int CLK_DIV    = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  spi_cmd_pkg::spi_cmd_t  cmd,
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  output logic                   sclk,
  output logic                   cs,
  output logic                   mosi,
  input  logic                   miso,
  output logic                   read_vld,
  output spi_cmd_pkg::spi_data_t read_data
);

  spi_cmd_pkg::spi_cmd_t fifo_cmd;
  logic                  fifo_valid;
  logic                  fifo_ready;

  // Commands queue here while a frame is on the wire.
  cmd_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) cmd_fifo_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_cmd    (cmd),
    .in_valid  (cmd_valid),
    .in_ready  (cmd_ready),
    .out_cmd   (fifo_cmd),
    .out_valid (fifo_valid),
    .out_ready (fifo_ready)
  );

  spi_master #(
    .CLK_DIV (CLK_DIV)
  ) spi_master_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (fifo_cmd),
    .cmd_valid (fifo_valid),
    .cmd_ready (fifo_ready),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

endmodule

`default_nettype wire

/* src/spi_master.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_master #(
  parameter int CLK_DIV = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  spi_cmd_pkg::spi_cmd_t  cmd,
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  output logic                   sclk,
  output logic                   cs,
  output logic                   mosi,
  input  logic                   miso,
  output logic                   read_vld,
  output spi_cmd_pkg::spi_data_t read_data
);

  localparam int CMD_BITS  = spi_cmd_pkg::CMD_BITS;
  localparam int READ_BITS = spi_cmd_pkg::READ_BITS;
  localparam int DIV_W     = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
  localparam int BIT_W     = $clog2(CMD_BITS);

  typedef logic [DIV_W-1:0] div_cnt_t;
  typedef logic [BIT_W-1:0] bit_cnt_t;

  typedef enum logic [2:0] {
    idle,
    setup,
    shift,
    read_shift,
    finish
  } spi_state_t;

  localparam div_cnt_t DIV_LAST  = div_cnt_t'(CLK_DIV - 1);
  localparam bit_cnt_t CMD_LAST  = bit_cnt_t'(CMD_BITS - 1);
  localparam bit_cnt_t READ_LAST = bit_cnt_t'(READ_BITS - 1);

  spi_state_t             state;
  div_cnt_t               div_cnt;
  bit_cnt_t               bit_cnt;
  logic                   rd_cmd;
  logic [CMD_BITS-1:0]    tx_shift;
  spi_cmd_pkg::spi_data_t rx_shift;
  logic                   pop;
  logic                   tick;
  logic                   sclk_rise;
  logic                   sclk_fall;

  assign cmd_ready = (state == idle); // One command per transaction.
  assign pop       = cmd_valid && cmd_ready;

  // ~~~~~~~~~~~~~~~~~~~~
  // Half-period divider

  assign tick      = (state != idle) && (div_cnt == DIV_LAST);
  assign sclk_rise = tick && !sclk &&
                     (state == setup || state == shift || state == read_shift);
  assign sclk_fall = tick && sclk;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt <= '0;
    end
    else if (state == idle || tick)
    begin
      div_cnt <= '0;
    end
    else
    begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sclk <= 1'b0;
    end
    else if (sclk_rise)
    begin
      sclk <= 1'b1;
    end
    else if (sclk_fall)
    begin
      sclk <= 1'b0;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Frame sequencing

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= idle;
      cs       <= 1'b1;
      mosi     <= 1'b0;
      rd_cmd   <= 1'b0;
      bit_cnt  <= '0;
      read_vld <= 1'b0;
    end
    else
    begin
      read_vld <= 1'b0;
      case (state)
        idle:
        begin
          if (pop)
          begin
            state   <= setup;
            cs      <= 1'b0;
            mosi    <= cmd.write; // MSB is ready before the first rising edge.
            rd_cmd  <= !cmd.write;
            bit_cnt <= '0;
          end
        end
        setup:
        begin
          if (tick)
          begin
            state <= shift;
          end
        end
        shift:
        begin
          if (sclk_fall)
          begin
            if (bit_cnt == CMD_LAST)
            begin
              bit_cnt <= '0;
              mosi    <= 1'b0;
              state   <= rd_cmd ? read_shift : finish;
            end
            else
            begin
              bit_cnt <= bit_cnt + 1'b1;
              mosi    <= tx_shift[CMD_BITS-2];
            end
          end
        end
        read_shift:
        begin
          if (sclk_fall)
          begin
            if (bit_cnt == READ_LAST)
            begin
              state <= finish;
            end
            else
            begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        finish:
        begin
          if (tick)
          begin
            cs       <= 1'b1;   // Release after one idle half period.
            read_vld <= rd_cmd;
            state    <= idle;
          end
        end
        default:
        begin
          state <= idle;
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Shift registers

  always_ff @(posedge clk)
  begin
    if (pop)
    begin
      tx_shift <= cmd;
    end
    else if (state == shift && sclk_fall)
    begin
      tx_shift <= {tx_shift[CMD_BITS-2:0], 1'b0};
    end
    if (state == read_shift && sclk_rise)
    begin
      rx_shift <= {rx_shift[READ_BITS-2:0], miso}; // Slave data arrives MSB first.
    end
  end

  assign read_data = rx_shift;

endmodule

`default_nettype wire

/* test/spi_cmd_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_tb;

  localparam int          FIFO_DEPTH = 4;
  localparam int          CLK_DIV    = 4;
  localparam int unsigned SEED       = 32'hc6be5ec2;
  localparam int          N_CMDS     = 8 + 16 + FIFO_DEPTH + 2 + 40;
  localparam int          MAX_CYCLES = N_CMDS * 25 * 2 * CLK_DIV + 200;

  logic                   clk;
  logic                   rst_n;
  spi_cmd_pkg::spi_cmd_t  cmd;
  logic                   cmd_valid;
  logic                   cmd_ready;
  logic                   sclk;
  logic                   cs;
  logic                   mosi;
  logic                   miso;
  logic                   read_vld;
  spi_cmd_pkg::spi_data_t read_data;

  spi_cmd_pkg::spi_data_t shadow [8];
  spi_cmd_pkg::spi_addr_t read_addr_q [$];
  spi_cmd_pkg::spi_data_t expect_q [$];
  spi_cmd_pkg::spi_addr_t exp_addr;
  spi_cmd_pkg::spi_data_t exp_data;
  int                     errors       = 0;
  int                     reads_issued = 0;
  int                     reads_seen   = 0;
  int                     cycles       = 0;
  logic                   saw_full     = 1'b0;

  spi_cmd_top #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .CLK_DIV    (CLK_DIV)
  ) spi_cmd_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_slave_model spi_slave_model_inst (
    .rst_n (rst_n),
    .sclk  (sclk),
    .cs    (cs),
    .mosi  (mosi),
    .miso  (miso)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Host side

  // Called on a falling edge; returns on the falling edge after the transfer.
  task automatic push_cmd(input logic write, input spi_cmd_pkg::spi_addr_t addr,
                          input spi_cmd_pkg::spi_data_t data);
    cmd.write = write;
    cmd.addr  = addr;
    cmd.data  = data;
    cmd_valid = 1'b1;
    while (!cmd_ready)
    begin
      saw_full = 1'b1;
      @(negedge clk);
    end
    if (write)
      shadow[addr] = data;
    else
    begin
      read_addr_q.push_back(addr);
      expect_q.push_back(shadow[addr]); // FIFO order keeps this value valid at pop time.
      reads_issued++;
    end
    @(negedge clk);
  endtask

  task automatic idle_cycles(input int n);
    cmd_valid = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  task automatic wait_drained;
    cmd_valid = 1'b0;
    while (expect_q.size() != 0 || !cs || spi_cmd_top_inst.fifo_valid)
      @(negedge clk);
  endtask

  // Read results are compared half a cycle after read_vld rises.
  always @(negedge clk)
  begin
    if (rst_n && read_vld)
    begin
      reads_seen++;
      if (expect_q.size() == 0)
      begin
        errors++;
        $display("Got a read_vld pulse at %0t with no read command pending", $time);
      end
      else
      begin
        exp_addr = read_addr_q.pop_front();
        exp_data = expect_q.pop_front();
        read_match: assert (read_data == exp_data)
        else
        begin
          errors++;
          $display("ERROR %0t: read of addr %0d gave %02h, expected %02h",
                   $time, exp_addr, read_data, exp_data);
        end
      end
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Test sequence

  initial
  begin
    int unsigned asrt_fails;
    void'($urandom(SEED));
    rst_n     = 1'b0;
    cmd       = '0;
    cmd_valid = 1'b0;
    for (int a = 0; a < 8; a++)
      shadow[a] = '0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    reset_state: assert (cs && !sclk && !mosi && !read_vld && cmd_ready)
    else
    begin
      errors++;
      $display("ERROR %0t: pins not at their reset values after reset", $time);
    end
    for (int a = 0; a < 8; a++) // Untouched registers read back zero.
      push_cmd(1'b0, spi_cmd_pkg::spi_addr_t'(a), spi_cmd_pkg::spi_data_t'($urandom()));
    wait_drained();
    for (int a = 0; a < 8; a++)
    begin
      push_cmd(1'b1, spi_cmd_pkg::spi_addr_t'(a), spi_cmd_pkg::spi_data_t'($urandom()));
      idle_cycles($urandom() % 4);
      push_cmd(1'b0, spi_cmd_pkg::spi_addr_t'(a), '0);
      idle_cycles($urandom() % 4);
    end
    wait_drained();
    saw_full = 1'b0;
    for (int k = 0; k < FIFO_DEPTH + 2; k++) // Back to back, valid stays high.
      push_cmd(k % 2 == 0, spi_cmd_pkg::spi_addr_t'(k / 2),
               spi_cmd_pkg::spi_data_t'($urandom()));
    wait_drained();
    burst_full: assert (saw_full)
    else
    begin
      errors++;
      $display("The burst never saw cmd_ready go low with the FIFO full");
    end
    repeat (40)
    begin
      push_cmd(1'($urandom()), spi_cmd_pkg::spi_addr_t'($urandom()),
               spi_cmd_pkg::spi_data_t'($urandom()));
      idle_cycles($urandom() % 6);
    end
    wait_drained();
    read_count: assert (reads_seen == reads_issued)
    else
    begin
      errors++;
      $display("ERROR %0t: %0d read_vld pulses for %0d reads", $time, reads_seen, reads_issued);
    end
    asrt_fails = spi_cmd_top_inst.spi_master_inst.spi_master_assertions_inst.fail_count;
    $display("Errors: %0d in checks, %0d in protocol assertions", errors, asrt_fails);
    if (errors == 0 && asrt_fails == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* test/spi_master_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_master_assertions (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic sclk,
  input wire logic cs,
  input wire logic mosi,
  input wire logic read_vld,
  input wire logic cmd_ready
);

  int unsigned fail_count = 0; // Number of failed protocol checks.

  sclk_low_when_idle: assert property (@(posedge clk) disable iff (!rst_n) cs |-> !sclk)
  else
  begin
    fail_count++;
    $error("sclk is high while cs is high");
  end

  mosi_stable_high: assert property (@(posedge clk) disable iff (!rst_n) sclk |-> $stable(mosi))
  else
  begin
    fail_count++;
    $error("mosi changed while sclk was high");
  end

  read_vld_single: assert property (@(posedge clk) disable iff (!rst_n) read_vld |=> !read_vld)
  else
  begin
    fail_count++;
    $error("read_vld lasted longer than one cycle");
  end

  read_vld_at_cs_rise: assert property (@(posedge clk) disable iff (!rst_n)
                                        read_vld |-> $rose(cs))
  else
  begin
    fail_count++;
    $error("read_vld without a rising cs");
  end

  ready_only_idle: assert property (@(posedge clk) disable iff (!rst_n) cmd_ready |-> cs)
  else
  begin
    fail_count++;
    $error("cmd_ready is high while cs is low");
  end

endmodule

bind spi_master spi_master_assertions spi_master_assertions_inst (
  .clk       (clk),
  .rst_n     (rst_n),
  .sclk      (sclk),
  .cs        (cs),
  .mosi      (mosi),
  .read_vld  (read_vld),
  .cmd_ready (cmd_ready)
);

`default_nettype wire

/* test/spi_slave_model.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_slave_model (
  input  wire logic rst_n,
  input  wire logic sclk,
  input  wire logic cs,
  input  wire logic mosi,
  output logic      miso
);

  localparam int CMD_BITS  = spi_cmd_pkg::CMD_BITS;
  localparam int READ_BITS = spi_cmd_pkg::READ_BITS;

  spi_cmd_pkg::spi_data_t regs [8];
  logic [CMD_BITS-1:0]    rx_frame;
  spi_cmd_pkg::spi_cmd_t  incoming;
  spi_cmd_pkg::spi_cmd_t  frame;    // Last complete command of this cs window.
  int                     bit_cnt;

  assign incoming = {rx_frame[CMD_BITS-2:0], mosi};

  // ~~~~~~~~~~~~~~~~~~~~
  // Command capture on rising sclk

  always @(posedge sclk or posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_cnt  <= 0;
      rx_frame <= '0;
      frame    <= '0;
      for (int i = 0; i < 8; i++)
        regs[i] <= '0;
    end
    else if (cs)
      bit_cnt <= 0;
    else
    begin
      rx_frame <= incoming;
      bit_cnt  <= bit_cnt + 1;
      if (bit_cnt == CMD_BITS - 1)
      begin
        frame <= incoming;
        if (incoming.write)
          regs[incoming.addr] <= incoming.data;
      end
    end
  end

  // Read data goes out MSB first, one bit per falling edge after the command.
  always @(negedge sclk or negedge rst_n)
  begin
    if (!rst_n)
      miso <= 1'b0;
    else if (!cs && !frame.write && bit_cnt >= CMD_BITS && bit_cnt < CMD_BITS + READ_BITS)
      miso <= regs[frame.addr][3'(CMD_BITS + READ_BITS - 1 - bit_cnt)];
  end

endmodule

`default_nettype wire
